/* rtl/mpm_pkg.sv */
package mpm_pkg;

  // Word and address geometry.
  localparam int DATA_W = 16;
  localparam int BANK_W = 2;
  localparam int ROW_W  = 4;
  localparam int ADDR_W = BANK_W + ROW_W;

  // Home banks and rows per bank.
  localparam int NUM_BANKS = 1 << BANK_W;
  localparam int NUM_ROWS  = 1 << ROW_W;

  // The spare sits after the last home bank in the bank array.
  localparam int SPARE_ID = NUM_BANKS;

  localparam int NUM_PORTS = 2;

  // A data word.
  typedef logic [DATA_W-1:0] data_t;

  // Port address, bank in the upper bits and row in the lower bits.
  typedef logic [ADDR_W-1:0] addr_t;

  // Home bank number.
  typedef logic [BANK_W-1:0] bank_t;

  // Row inside a bank.
  typedef logic [ROW_W-1:0] row_t;

  // Physical bank number, one extra bit to reach the spare.
  typedef logic [BANK_W:0] phys_t;

endpackage

/* rtl/bank_if.sv */
`timescale 1ns/1ps

interface bank_if import mpm_pkg::*; ();

  // Write port.
  logic  we;
  row_t  waddr;
  data_t wdata;

  // Two read ports, one per memory port.
  row_t  raddr0;
  row_t  raddr1;
  data_t rdata0;
  data_t rdata1;

  // Controller side, slot 0 of the spare feeds evictions.
  modport ctrl (
    output we,
    output waddr,
    output wdata,
    output raddr0,
    output raddr1,
    input  rdata0
  );

  modport mem (
    input  we,
    input  waddr,
    input  wdata,
    input  raddr0,
    input  raddr1,
    output rdata0,
    output rdata1
  );

  modport sink (
    input rdata0,
    input rdata1
  );

endinterface

/* rtl/bank_ram.sv */
`timescale 1ns/1ps

module bank_ram import mpm_pkg::*; (
  input logic  clk,
  bank_if.mem  mem
);

  data_t ram [NUM_ROWS];

  // One write per cycle, taken at the edge.
  always_ff @(posedge clk) begin
    if (mem.we) begin
      ram[mem.waddr] <= mem.wdata;
    end
  end

  // Reads are asynchronous and show the contents before this edge's write.
  assign mem.rdata0 = ram[mem.raddr0];
  assign mem.rdata1 = ram[mem.raddr1];

endmodule

/* rtl/remap_table.sv */
`timescale 1ns/1ps

module remap_table import mpm_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  row_t                 map_row [NUM_PORTS],
  output logic [NUM_PORTS-1:0] map_vld,
  output bank_t                map_bank [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] upd_set,
  input  logic [NUM_PORTS-1:0] upd_clr,
  input  row_t                 upd_row [NUM_PORTS],
  input  bank_t                upd_bank [NUM_PORTS]
);

  // Per row, which home bank currently lives in the spare.
  logic [NUM_ROWS-1:0] row_vld;
  bank_t               row_bank [NUM_ROWS];

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      map_vld[p]  = row_vld[map_row[p]];
      map_bank[p] = row_bank[map_row[p]];
    end
  end

  // A clear only drops the entry if it still names the given bank.
  always_ff @(posedge clk) begin
    if (rst) begin
      row_vld <= '0;
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (upd_set[p]) begin
          row_vld[upd_row[p]] <= 1'b1;
        end else if (upd_clr[p] && (row_bank[upd_row[p]] == upd_bank[p])) begin
          row_vld[upd_row[p]] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (upd_set[p]) begin
        row_bank[upd_row[p]] <= upd_bank[p];
      end
    end
  end

endmodule

/* rtl/access_ctrl.sv */
`timescale 1ns/1ps

module access_ctrl import mpm_pkg::*; (
  input  logic [NUM_PORTS-1:0] read,
  input  logic [NUM_PORTS-1:0] write,
  input  addr_t                addr [NUM_PORTS],
  input  data_t                din [NUM_PORTS],
  output row_t                 map_row [NUM_PORTS],
  input  logic [NUM_PORTS-1:0] map_vld,
  input  bank_t                map_bank [NUM_PORTS],
  output logic [NUM_PORTS-1:0] upd_set,
  output logic [NUM_PORTS-1:0] upd_clr,
  output row_t                 upd_row [NUM_PORTS],
  output bank_t                upd_bank [NUM_PORTS],
  bank_if.ctrl                 banks [NUM_BANKS+1],
  output logic [NUM_PORTS-1:0] rd_req,
  output phys_t                rd_phys [NUM_PORTS]
);

  bank_t                bank [NUM_PORTS];
  row_t                 row [NUM_PORTS];
  logic [NUM_PORTS-1:0] hit_own;
  logic                 same_addr;
  logic                 conflict;
  logic                 wr0;
  logic                 evict;
  logic                 bank_we [NUM_BANKS+1];
  row_t                 bank_waddr [NUM_BANKS+1];
  data_t                bank_wdata [NUM_BANKS+1];
  data_t                spare_old;

  // Address split, map lookup and read routing.
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      bank[p]    = addr[p][ADDR_W-1 -: BANK_W];
      row[p]     = addr[p][ROW_W-1:0];
      map_row[p] = row[p];
      hit_own[p] = map_vld[p] && (map_bank[p] == bank[p]);
      rd_req[p]  = read[p];
      rd_phys[p] = hit_own[p] ? phys_t'(SPARE_ID) : {1'b0, bank[p]};
    end
  end

  // Port 1 wins an equal address.
  assign same_addr = (&write) && (addr[0] == addr[1]);
  assign conflict  = (&write) && (bank[0] == bank[1]) && (row[0] != row[1]);
  assign wr0       = write[0] && !same_addr;

  // Spare row already holds another bank's word, push it home.
  assign evict = wr0 && conflict && map_vld[0] && !hit_own[0];

  always_comb begin
    upd_set[0] = wr0 && conflict;
    upd_clr[0] = wr0 && !conflict && hit_own[0];
    upd_set[1] = 1'b0;
    upd_clr[1] = write[1] && hit_own[1];
    upd_row    = row;
    upd_bank   = bank;
  end

  always_comb begin
    for (int k = 0; k <= NUM_BANKS; k++) begin
      bank_we[k]    = 1'b0;
      bank_waddr[k] = row[0];
      bank_wdata[k] = din[0];
    end
    if (write[1]) begin
      bank_we[bank[1]]    = 1'b1;
      bank_waddr[bank[1]] = row[1];
      bank_wdata[bank[1]] = din[1];
    end
    if (wr0 && conflict) begin
      bank_we[SPARE_ID]    = 1'b1;
      bank_waddr[SPARE_ID] = row[0];
      bank_wdata[SPARE_ID] = din[0];
    end else if (wr0) begin
      bank_we[bank[0]]    = 1'b1;
      bank_waddr[bank[0]] = row[0];
      bank_wdata[bank[0]] = din[0];
    end
    // Evicted bank differs from the conflicting bank, so it is idle here.
    if (evict) begin
      bank_we[map_bank[0]]    = 1'b1;
      bank_waddr[map_bank[0]] = row[0];
      bank_wdata[map_bank[0]] = spare_old;
    end
  end

  // Every bank reads both port rows; read_pipe picks the slot it needs.
  for (genvar k = 0; k <= NUM_BANKS; k++) begin : g_drive
    assign banks[k].we     = bank_we[k];
    assign banks[k].waddr  = bank_waddr[k];
    assign banks[k].wdata  = bank_wdata[k];
    assign banks[k].raddr0 = row[0];
    assign banks[k].raddr1 = row[1];
  end

  assign spare_old = banks[SPARE_ID].rdata0;

endmodule

/* rtl/read_pipe.sv */
`timescale 1ns/1ps

module read_pipe import mpm_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  bank_if.sink                 banks [NUM_BANKS+1],
  input  logic [NUM_PORTS-1:0] rd_req,
  input  phys_t                rd_phys [NUM_PORTS],
  output logic [NUM_PORTS-1:0] rd_vld,
  output data_t                rd_dout [NUM_PORTS]
);

  data_t                slot_data [NUM_PORTS][NUM_BANKS+1];
  data_t                sel_data [NUM_PORTS];
  logic [NUM_PORTS-1:0] s1_vld;
  data_t                s1_data [NUM_PORTS];

  // Port p always uses read slot p of each bank.
  for (genvar k = 0; k <= NUM_BANKS; k++) begin : g_slot
    assign slot_data[0][k] = banks[k].rdata0;
    assign slot_data[1][k] = banks[k].rdata1;
  end

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      sel_data[p] = slot_data[p][rd_phys[p]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld <= '0;
      rd_vld <= '0;
    end else begin
      s1_vld <= rd_req;
      rd_vld <= s1_vld;
    end
  end

  // Data stages only load behind a valid.
  always_ff @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (rd_req[p]) begin
        s1_data[p] <= sel_data[p];
      end
      if (s1_vld[p]) begin
        rd_dout[p] <= s1_data[p];
      end
    end
  end

endmodule

/* rtl/mpm_top.sv */
`timescale 1ns/1ps

module mpm_top import mpm_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_PORTS-1:0] read,
  input  logic [NUM_PORTS-1:0] write,
  input  addr_t                addr [NUM_PORTS],
  input  data_t                din [NUM_PORTS],
  output logic [NUM_PORTS-1:0] rd_vld,
  output data_t                rd_dout [NUM_PORTS]
);

  row_t                 map_row [NUM_PORTS];
  logic [NUM_PORTS-1:0] map_vld;
  bank_t                map_bank [NUM_PORTS];
  logic [NUM_PORTS-1:0] upd_set;
  logic [NUM_PORTS-1:0] upd_clr;
  row_t                 upd_row [NUM_PORTS];
  bank_t                upd_bank [NUM_PORTS];
  logic [NUM_PORTS-1:0] rd_req;
  phys_t                rd_phys [NUM_PORTS];

  // Home banks first, spare last.
  bank_if banks [NUM_BANKS+1] ();

  access_ctrl u_ctrl (
    .read     (read),
    .write    (write),
    .addr     (addr),
    .din      (din),
    .map_row  (map_row),
    .map_vld  (map_vld),
    .map_bank (map_bank),
    .upd_set  (upd_set),
    .upd_clr  (upd_clr),
    .upd_row  (upd_row),
    .upd_bank (upd_bank),
    .banks    (banks),
    .rd_req   (rd_req),
    .rd_phys  (rd_phys)
  );

  remap_table u_map (
    .clk      (clk),
    .rst      (rst),
    .map_row  (map_row),
    .map_vld  (map_vld),
    .map_bank (map_bank),
    .upd_set  (upd_set),
    .upd_clr  (upd_clr),
    .upd_row  (upd_row),
    .upd_bank (upd_bank)
  );

  for (genvar k = 0; k <= NUM_BANKS; k++) begin : g_bank
    bank_ram u_bank (
      .clk (clk),
      .mem (banks[k])
    );
  end

  read_pipe u_rd (
    .clk     (clk),
    .rst     (rst),
    .banks   (banks),
    .rd_req  (rd_req),
    .rd_phys (rd_phys),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

endmodule

/* bench/mpm_checker.sv */
`timescale 1ns/1ps

module mpm_checker import mpm_pkg::*; (
  input logic                 clk,
  input logic                 rst,
  input logic [NUM_PORTS-1:0] read,
  input logic [NUM_PORTS-1:0] write,
  input addr_t                addr [NUM_PORTS],
  input data_t                din [NUM_PORTS],
  input logic [NUM_PORTS-1:0] rd_vld,
  input data_t                rd_dout [NUM_PORTS]
);

  // Flat view of the memory, one word per port address.
  data_t                    shadow [1 << ADDR_W];
  logic [(1 << ADDR_W)-1:0] written;

  logic [NUM_PORTS-1:0] exp_vld1;
  logic [NUM_PORTS-1:0] exp_vld2;
  logic [NUM_PORTS-1:0] exp_known1;
  logic [NUM_PORTS-1:0] exp_known2;
  data_t                exp_data1 [NUM_PORTS];
  data_t                exp_data2 [NUM_PORTS];

  int fail_count = 0;

  // Reads capture the word before this edge's writes; port 1 writes last.
  always_ff @(posedge clk) begin
    if (rst) begin
      written  <= '0;
      exp_vld1 <= '0;
      exp_vld2 <= '0;
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        exp_vld1[p]   <= read[p];
        exp_known1[p] <= written[addr[p]];
        exp_data1[p]  <= shadow[addr[p]];
        exp_vld2[p]   <= exp_vld1[p];
        exp_known2[p] <= exp_known1[p];
        exp_data2[p]  <= exp_data1[p];
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (write[p]) begin
          shadow[addr[p]]  <= din[p];
          written[addr[p]] <= 1'b1;
        end
      end
    end
  end

  a_rd_vld: assert property (@(posedge clk) disable iff (rst) rd_vld == exp_vld2)
  else begin
    fail_count++;
    $error("MISMATCH at %0t: rd_vld got %b expected %b", $time,
           $sampled(rd_vld), $sampled(exp_vld2));
  end

  // Words never written carry no expected value.
  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
    a_rd_data: assert property (@(posedge clk) disable iff (rst)
      (rd_vld[p] && exp_known2[p]) |-> (rd_dout[p] == exp_data2[p]))
    else begin
      fail_count++;
      $error("MISMATCH at %0t: rd_dout[%0d] got %h expected %h", $time, p,
             $sampled(rd_dout[p]), $sampled(exp_data2[p]));
    end
  end

endmodule

bind mpm_top mpm_checker u_chk (
  .clk     (clk),
  .rst     (rst),
  .read    (read),
  .write   (write),
  .addr    (addr),
  .din     (din),
  .rd_vld  (rd_vld),
  .rd_dout (rd_dout)
);

/* bench/mpm_tb.sv */
`timescale 1ns/1ps

module mpm_tb import mpm_pkg::*; ();

  localparam int CLK_PERIOD      = 100;
  localparam int DRIVE_DLY       = 5;
  localparam int RESET_CYCLES    = 16;
  localparam int DIRECTED_CYCLES = 38;
  localparam int RANDOM_CYCLES   = 400;
  localparam int DRAIN_CYCLES    = 4;
  localparam int TEST_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES
                                   + DRAIN_CYCLES;
  localparam int WATCHDOG_NS     = 20 * TEST_CYCLES * CLK_PERIOD;

  logic                 clk;
  logic                 rst;
  logic [NUM_PORTS-1:0] read;
  logic [NUM_PORTS-1:0] write;
  addr_t                addr [NUM_PORTS];
  data_t                din [NUM_PORTS];
  logic [NUM_PORTS-1:0] rd_vld;
  data_t                rd_dout [NUM_PORTS];
  logic [15:0]          lfsr;

  mpm_top u_dut (
    .clk     (clk),
    .rst     (rst),
    .read    (read),
    .write   (write),
    .addr    (addr),
    .din     (din),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Taps 16, 14, 13, 11.
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic addr_t make_addr(input int b, input int r);
    return {bank_t'(b), row_t'(r)};
  endfunction

  task automatic set_port(input int p, input logic rd, input logic wr, input addr_t a,
                          input data_t d);
    read[p]  = rd;
    write[p] = wr;
    addr[p]  = a;
    din[p]   = d;
  endtask

  // Inputs return to idle after every edge.
  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
    read  = '0;
    write = '0;
  endtask

  task automatic single_port_phase();
    for (int i = 0; i < 8; i++) begin
      set_port(i % 2, 1'b0, 1'b1, make_addr(i % 4, i + 3), data_t'(16'hA000 + i));
      next_cycle();
    end
    for (int i = 0; i < 8; i++) begin
      set_port(0, 1'b1, 1'b0, make_addr(i % 4, i + 3), '0);
      set_port(1, 1'b1, 1'b0, make_addr((7 - i) % 4, 10 - i), '0);
      next_cycle();
    end
  endtask

  task automatic conflict_phase();
    for (int i = 0; i < 4; i++) begin
      set_port(0, 1'b0, 1'b1, make_addr(i, 2), data_t'(16'hB000 + i));
      set_port(1, 1'b0, 1'b1, make_addr(i, 12), data_t'(16'hB100 + i));
      next_cycle();
    end
    for (int i = 0; i < 4; i++) begin
      set_port(0, 1'b1, 1'b0, make_addr(i, 12), '0);
      set_port(1, 1'b1, 1'b0, make_addr(i, 2), '0);
      next_cycle();
    end
  endtask

  // Bank 0 row 5 moves to the spare, then bank 2 row 5 pushes it home.
  task automatic evict_phase();
    set_port(0, 1'b0, 1'b1, make_addr(0, 5), 16'hC005);
    set_port(1, 1'b0, 1'b1, make_addr(0, 2), 16'hC002);
    next_cycle();
    set_port(0, 1'b0, 1'b1, make_addr(2, 5), 16'hC025);
    set_port(1, 1'b0, 1'b1, make_addr(2, 7), 16'hC027);
    next_cycle();
    set_port(0, 1'b1, 1'b0, make_addr(0, 5), '0);
    set_port(1, 1'b1, 1'b0, make_addr(2, 5), '0);
    next_cycle();
    set_port(0, 1'b1, 1'b0, make_addr(2, 7), '0);
    set_port(1, 1'b1, 1'b0, make_addr(0, 2), '0);
    next_cycle();
  endtask

  task automatic same_addr_phase();
    for (int i = 0; i < 2; i++) begin
      set_port(0, 1'b0, 1'b1, make_addr(3, 6 + i), data_t'(16'hD000 + i));
      set_port(1, 1'b0, 1'b1, make_addr(3, 6 + i), data_t'(16'hD100 + i));
      next_cycle();
      set_port(0, 1'b1, 1'b0, make_addr(3, 6 + i), '0);
      set_port(1, 1'b1, 1'b0, make_addr(3, 6 + i), '0);
      next_cycle();
    end
  endtask

  task automatic read_write_phase();
    for (int w = 0; w < NUM_PORTS; w++) begin
      set_port(w, 1'b0, 1'b1, make_addr(1, 4 + w), data_t'(16'hE000 + w));
      next_cycle();
      set_port(w, 1'b0, 1'b1, make_addr(1, 4 + w), data_t'(16'hE100 + w));
      set_port(1 - w, 1'b1, 1'b0, make_addr(1, 4 + w), '0);
      next_cycle();
      set_port(1 - w, 1'b1, 1'b0, make_addr(1, 4 + w), '0);
      next_cycle();
    end
  endtask

  // Each port either reads or writes in a cycle.
  task automatic random_phase();
    logic [1:0] op;
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        op = 2'(rand_bits(2));
        set_port(p, op[0], op[1] && !op[0], addr_t'(rand_bits(ADDR_W)),
                 data_t'(rand_bits(DATA_W)));
      end
      next_cycle();
    end
  endtask

  initial begin
    clk   = 1'b0;
    rst   = 1'b1;
    read  = '0;
    write = '0;
    addr  = '{default: '0};
    din   = '{default: '0};
    lfsr  = 16'd6;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;
    single_port_phase();
    conflict_phase();
    evict_phase();
    same_addr_phase();
    read_write_phase();
    random_phase();
    repeat (DRAIN_CYCLES) next_cycle();
    if (u_dut.u_chk.fail_count != 0) begin
      $display("*** TEST FAILED ***");
      $fatal(1, "assertion failures were reported during the run");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

  initial begin
    wait (u_dut.u_chk.fail_count != 0);
    $display("*** TEST FAILED ***");
    $fatal(1, "a checker assertion failed, see the MISMATCH line above");
  end

  initial begin
    #(WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog timeout, the simulation did not finish in time");
  end

endmodule

/* compile.f */
rtl/mpm_pkg.sv
rtl/bank_if.sv
rtl/bank_ram.sv
rtl/remap_table.sv
rtl/access_ctrl.sv
rtl/read_pipe.sv
rtl/mpm_top.sv
bench/mpm_checker.sv
bench/mpm_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := mpm_tb
FILELIST   := compile.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP)
LINT_FLAGS := --lint-only --timing --assert --top-module $(TOP)
SIM_ARGS   := +verilator+error+limit+1000
LOG        := sim.log
FAIL_MSG   := *** TEST FAILED ***
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "Simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
